/* design/sw_pkg.sv */
package sw_pkg;

	// array size, one S base per PE
	localparam int PE_NUM = 8;
	localparam int PE_NUM_LOG = 4;

	// query buffer
	localparam int MAX_T = 32;
	localparam int MAX_T_LOG = 6;

	// signed score width inside the array
	localparam int SCORE_W = 12;
	// user reward and penalties, given as positive magnitudes
	localparam int PARAM_W = 8;

	// reset defaults
	localparam int DEF_MATCH = 6;
	localparam int DEF_MISMATCH = 1;
	localparam int DEF_OPEN = 2;
	localparam int DEF_EXTEND = 1;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		SETT  = 2'd1,
		CALC  = 2'd2,
		DRAIN = 2'd3
	} ctrl_state_t;

endpackage

/* design/sw_pe.sv */
`timescale 1ns/1ps

module sw_pe (
	input  logic clk,
	input  logic rst_n,
	input  logic i_clear,
	input  logic i_enable,
	input  logic [1:0] i_s_base,
	input  logic [1:0] i_t_base,
	input  logic i_t_valid,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_h_left,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_f_left,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_match,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_mismatch,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_open,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_extend,
	output logic [1:0] o_t_base,
	output logic o_t_valid,
	output logic signed [sw_pkg::SCORE_W-1:0] o_h,
	output logic signed [sw_pkg::SCORE_W-1:0] o_f
);

	// o_h doubles as H of the row above
	logic signed [sw_pkg::SCORE_W-1:0] e_q;
	logic signed [sw_pkg::SCORE_W-1:0] h_diag;

	logic signed [sw_pkg::SCORE_W-1:0] e_from_h;
	logic signed [sw_pkg::SCORE_W-1:0] e_from_e;
	logic signed [sw_pkg::SCORE_W-1:0] f_from_h;
	logic signed [sw_pkg::SCORE_W-1:0] f_from_f;
	logic signed [sw_pkg::SCORE_W-1:0] e_new;
	logic signed [sw_pkg::SCORE_W-1:0] f_new;
	logic signed [sw_pkg::SCORE_W-1:0] diag_score;
	logic signed [sw_pkg::SCORE_W-1:0] h_new;

	always_comb begin
		e_from_h = o_h + i_open;
		e_from_e = e_q + i_extend;
		f_from_h = i_h_left + i_open;
		f_from_f = i_f_left + i_extend;
		e_new = (e_from_h > e_from_e) ? e_from_h : e_from_e;
		f_new = (f_from_h > f_from_f) ? f_from_h : f_from_f;
		diag_score = h_diag + ((i_t_base == i_s_base) ? i_match : i_mismatch);

		// local alignment floors at zero
		h_new = '0;
		if (e_new > h_new)
			h_new = e_new;
		if (f_new > h_new)
			h_new = f_new;
		if (diag_score > h_new)
			h_new = diag_score;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_t_valid <= 1'b0;
			o_h <= '0;
			o_f <= '0;
			e_q <= '0;
			h_diag <= '0;
		end else if (i_clear) begin
			o_t_valid <= 1'b0;
			o_h <= '0;
			o_f <= '0;
			e_q <= '0;
			h_diag <= '0;
		end else begin
			o_t_valid <= i_t_valid;
			if (i_t_valid && i_enable) begin
				o_h <= h_new;
				o_f <= f_new;
				e_q <= e_new;
				// left H now becomes next row's diagonal
				h_diag <= i_h_left;
			end
		end
	end

	always_ff @(posedge clk) begin
		o_t_base <= i_t_base;
	end

endmodule

/* design/t_store.sv */
`timescale 1ns/1ps

module t_store (
	input  logic clk,
	input  logic rst_n,
	input  logic i_load_start,
	input  logic [sw_pkg::MAX_T_LOG-1:0] i_load_len,
	input  logic [1:0] i_base,
	input  logic i_base_valid,
	input  logic i_play_start,
	output logic o_base_ready,
	output logic o_loading,
	output logic [sw_pkg::MAX_T_LOG-1:0] o_t_len,
	output logic [1:0] o_play_base,
	output logic o_play_valid,
	output logic o_play_last
);

	logic [1:0] mem [0:sw_pkg::MAX_T-1];
	logic [sw_pkg::MAX_T_LOG-1:0] wr_ptr;
	logic [sw_pkg::MAX_T_LOG-1:0] rd_ptr;
	logic [sw_pkg::MAX_T_LOG-1:0] len_clamped;
	logic loading;

	always_comb begin
		if (i_load_len == '0)
			len_clamped = sw_pkg::MAX_T_LOG'(1);
		else if (i_load_len > sw_pkg::MAX_T_LOG'(sw_pkg::MAX_T))
			len_clamped = sw_pkg::MAX_T_LOG'(sw_pkg::MAX_T);
		else
			len_clamped = i_load_len;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			loading <= 1'b0;
			wr_ptr <= '0;
			o_t_len <= '0;
		end else if (i_load_start) begin
			loading <= 1'b1;
			wr_ptr <= '0;
			o_t_len <= len_clamped;
		end else if (loading && i_base_valid) begin
			wr_ptr <= wr_ptr + sw_pkg::MAX_T_LOG'(1);
			if (wr_ptr + sw_pkg::MAX_T_LOG'(1) == o_t_len)
				loading <= 1'b0;
		end
	end

	// only pointer values below MAX_T address live entries
	always_ff @(posedge clk) begin
		if (loading && i_base_valid)
			mem[wr_ptr[sw_pkg::MAX_T_LOG-2:0]] <= i_base;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_play_valid <= 1'b0;
			o_play_last <= 1'b0;
			rd_ptr <= '0;
		end else if (i_play_start) begin
			o_play_valid <= 1'b1;
			o_play_last <= (o_t_len == sw_pkg::MAX_T_LOG'(1));
			rd_ptr <= sw_pkg::MAX_T_LOG'(1);
		end else if (o_play_valid && !o_play_last) begin
			o_play_last <= (rd_ptr + sw_pkg::MAX_T_LOG'(1) == o_t_len);
			rd_ptr <= rd_ptr + sw_pkg::MAX_T_LOG'(1);
		end else begin
			o_play_valid <= 1'b0;
			o_play_last <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_play_start)
			o_play_base <= mem[0];
		else if (o_play_valid)
			o_play_base <= mem[rd_ptr[sw_pkg::MAX_T_LOG-2:0]];
	end

	assign o_base_ready = loading;
	assign o_loading = loading;

endmodule

/* design/pe_array.sv */
`timescale 1ns/1ps

module pe_array (
	input  logic clk,
	input  logic rst_n,
	input  logic i_start,
	input  logic [sw_pkg::PE_NUM*2-1:0] i_s,
	input  logic [sw_pkg::PE_NUM_LOG-1:0] i_s_len,
	input  logic [1:0] i_t_base,
	input  logic i_t_valid,
	input  logic i_t_last,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_match,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_mismatch,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_open,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_extend,
	output logic signed [sw_pkg::SCORE_W-1:0] o_result,
	output logic o_done
);

	// index 0 is the left boundary, index k+1 is the output of PE k
	logic [1:0] t_chain [0:sw_pkg::PE_NUM];
	logic v_chain [0:sw_pkg::PE_NUM];
	logic signed [sw_pkg::SCORE_W-1:0] h_chain [0:sw_pkg::PE_NUM];
	logic signed [sw_pkg::SCORE_W-1:0] f_chain [0:sw_pkg::PE_NUM];

	logic [sw_pkg::PE_NUM-1:0] last_sr;
	logic signed [sw_pkg::SCORE_W-1:0] max_next;

	assign t_chain[0] = i_t_base;
	assign v_chain[0] = i_t_valid;
	assign h_chain[0] = '0;
	assign f_chain[0] = '0;

	for (genvar k = 0; k < sw_pkg::PE_NUM; k++) begin : g_pe
		sw_pe u_pe (
			.clk        (clk),
			.rst_n      (rst_n),
			.i_clear    (i_start),
			.i_enable   (i_s_len > sw_pkg::PE_NUM_LOG'(k)),
			.i_s_base   (i_s[2*k+1:2*k]),
			.i_t_base   (t_chain[k]),
			.i_t_valid  (v_chain[k]),
			.i_h_left   (h_chain[k]),
			.i_f_left   (f_chain[k]),
			.i_match    (i_match),
			.i_mismatch (i_mismatch),
			.i_open     (i_open),
			.i_extend   (i_extend),
			.o_t_base   (t_chain[k+1]),
			.o_t_valid  (v_chain[k+1]),
			.o_h        (h_chain[k+1]),
			.o_f        (f_chain[k+1])
		);
	end

	// disabled cells sit at 0, so they never raise the max
	always_comb begin
		max_next = o_result;
		for (int j = 1; j <= sw_pkg::PE_NUM; j++) begin
			if (h_chain[j] > max_next)
				max_next = h_chain[j];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_result <= '0;
			last_sr <= '0;
			o_done <= 1'b0;
		end else if (i_start) begin
			o_result <= '0;
			last_sr <= '0;
			o_done <= 1'b0;
		end else begin
			o_result <= max_next;
			last_sr <= {last_sr[sw_pkg::PE_NUM-2:0], i_t_last & i_t_valid};
			// last base just left the final PE, max settles this edge
			o_done <= last_sr[sw_pkg::PE_NUM-1] & v_chain[sw_pkg::PE_NUM];
		end
	end

endmodule

/* design/sw_top.sv */
`timescale 1ns/1ps

module sw_top (
	input  logic clk,
	input  logic rst_n,

	// query load
	input  logic i_set_t,
	input  logic [sw_pkg::MAX_T_LOG-1:0] i_t_len,
	input  logic [1:0] i_t_base,
	input  logic i_t_valid,
	output logic o_t_ready,

	// calculation
	input  logic i_start_cal,
	input  logic [sw_pkg::PE_NUM*2-1:0] i_s,
	input  logic [sw_pkg::PE_NUM_LOG-1:0] i_s_len,

	// scoring
	input  logic [sw_pkg::PARAM_W-1:0] i_match,
	input  logic [sw_pkg::PARAM_W-1:0] i_mismatch,
	input  logic [sw_pkg::PARAM_W-1:0] i_gap_open,
	input  logic [sw_pkg::PARAM_W-1:0] i_gap_extend,
	input  logic i_param_valid,

	output logic o_busy,
	output logic signed [sw_pkg::SCORE_W-1:0] o_result,
	output logic o_valid
);

	logic set_t_r;
	logic start_r;
	logic param_valid_r;
	logic [sw_pkg::MAX_T_LOG-1:0] t_len_r;
	logic [sw_pkg::PE_NUM*2-1:0] s_r;
	logic [sw_pkg::PE_NUM_LOG-1:0] s_len_r;
	logic [sw_pkg::PARAM_W-1:0] match_r;
	logic [sw_pkg::PARAM_W-1:0] mismatch_r;
	logic [sw_pkg::PARAM_W-1:0] open_r;
	logic [sw_pkg::PARAM_W-1:0] extend_r;

	sw_pkg::ctrl_state_t state;
	sw_pkg::ctrl_state_t n_state;
	logic load_start;
	logic play_start;

	// S as latched at the start of a run
	logic [sw_pkg::PE_NUM*2-1:0] s_cal;
	logic [sw_pkg::PE_NUM_LOG-1:0] s_len_cal;

	logic signed [sw_pkg::SCORE_W-1:0] score_match;
	logic signed [sw_pkg::SCORE_W-1:0] score_mismatch;
	logic signed [sw_pkg::SCORE_W-1:0] score_open;
	logic signed [sw_pkg::SCORE_W-1:0] score_extend;

	logic loading;
	logic [sw_pkg::MAX_T_LOG-1:0] t_len;
	logic [1:0] t_base;
	logic t_base_valid;
	logic t_base_last;

	logic signed [sw_pkg::SCORE_W-1:0] array_result;
	logic array_done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			set_t_r <= 1'b0;
			start_r <= 1'b0;
			param_valid_r <= 1'b0;
		end else begin
			set_t_r <= i_set_t;
			start_r <= i_start_cal;
			param_valid_r <= i_param_valid;
		end
	end

	always_ff @(posedge clk) begin
		t_len_r <= i_t_len;
		s_r <= i_s;
		s_len_r <= i_s_len;
		match_r <= i_match;
		mismatch_r <= i_mismatch;
		open_r <= i_gap_open;
		extend_r <= i_gap_extend;
	end

	always_comb begin
		n_state = state;
		load_start = 1'b0;
		play_start = 1'b0;
		case (state)
			sw_pkg::IDLE: begin
				if (set_t_r) begin
					n_state = sw_pkg::SETT;
					load_start = 1'b1;
				end else if (start_r && (t_len != '0)) begin
					n_state = sw_pkg::CALC;
					play_start = 1'b1;
				end
			end
			sw_pkg::SETT: begin
				if (!loading)
					n_state = sw_pkg::IDLE;
			end
			sw_pkg::CALC: begin
				if (array_done)
					n_state = sw_pkg::DRAIN;
			end
			default: n_state = sw_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= sw_pkg::IDLE;
			o_busy <= 1'b0;
			o_valid <= 1'b0;
			o_result <= '0;
		end else begin
			state <= n_state;
			o_busy <= (n_state != sw_pkg::IDLE);
			o_valid <= array_done;
			// result is held until the next run finishes
			if (array_done)
				o_result <= array_result;
		end
	end

	// penalties become negative, match stays positive
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score_match <= sw_pkg::SCORE_W'(sw_pkg::DEF_MATCH);
			score_mismatch <= -sw_pkg::SCORE_W'(sw_pkg::DEF_MISMATCH);
			score_open <= -sw_pkg::SCORE_W'(sw_pkg::DEF_OPEN);
			score_extend <= -sw_pkg::SCORE_W'(sw_pkg::DEF_EXTEND);
		end else if (param_valid_r && (state != sw_pkg::CALC)) begin
			score_match <= sw_pkg::SCORE_W'(match_r);
			score_mismatch <= -sw_pkg::SCORE_W'(mismatch_r);
			score_open <= -sw_pkg::SCORE_W'(open_r);
			score_extend <= -sw_pkg::SCORE_W'(extend_r);
		end
	end

	always_ff @(posedge clk) begin
		if (play_start) begin
			s_cal <= s_r;
			s_len_cal <= s_len_r;
		end
	end

	t_store u_t_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_load_start (load_start),
		.i_load_len   (t_len_r),
		.i_base       (i_t_base),
		.i_base_valid (i_t_valid),
		.i_play_start (play_start),
		.o_base_ready (o_t_ready),
		.o_loading    (loading),
		.o_t_len      (t_len),
		.o_play_base  (t_base),
		.o_play_valid (t_base_valid),
		.o_play_last  (t_base_last)
	);

	pe_array u_pe_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_start    (play_start),
		.i_s        (s_cal),
		.i_s_len    (s_len_cal),
		.i_t_base   (t_base),
		.i_t_valid  (t_base_valid),
		.i_t_last   (t_base_last),
		.i_match    (score_match),
		.i_mismatch (score_mismatch),
		.i_open     (score_open),
		.i_extend   (score_extend),
		.o_result   (array_result),
		.o_done     (array_done)
	);

endmodule

/* test/sw_checker.sv */
`timescale 1ns/1ps

module sw_checker (
	input logic clk,
	input logic rst_n,
	input logic i_valid,
	input logic i_busy,
	input logic i_t_ready
);

	// result only comes out of a running calculation
	valid_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
		i_valid |-> $past(i_busy))
		else $error("o_valid rose without o_busy in the cycle before");

	// single cycle result pulse
	valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		i_valid |=> !i_valid)
		else $error("o_valid stayed high for two cycles");

	valid_not_loading: assert property (@(posedge clk) disable iff (!rst_n)
		i_valid |-> !i_t_ready)
		else $error("o_t_ready high while o_valid is high");

	// first cycle out of reset
	idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !i_busy)
		else $error("o_busy high right after reset");

endmodule

bind sw_top sw_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.i_valid   (o_valid),
	.i_busy    (o_busy),
	.i_t_ready (o_t_ready)
);

/* test/sw_tb.sv */
`timescale 1ns/1ps

module sw_tb;

	localparam int N_DEF = 6;
	localparam int N_PARAM = 4;
	localparam int N_MID = 3;
	localparam int N_SLEN = 6;
	localparam int N_NEW = 4;
	// reset check and two loads count as tests too
	localparam int N_TESTS = 3 + N_DEF + N_PARAM + N_MID + N_SLEN + N_NEW;
	localparam int NEG_INF = -100000;

	logic clk;
	logic rst_n;
	logic i_set_t;
	logic [sw_pkg::MAX_T_LOG-1:0] i_t_len;
	logic [1:0] i_t_base;
	logic i_t_valid;
	logic o_t_ready;
	logic i_start_cal;
	logic [sw_pkg::PE_NUM*2-1:0] i_s;
	logic [sw_pkg::PE_NUM_LOG-1:0] i_s_len;
	logic [sw_pkg::PARAM_W-1:0] i_match;
	logic [sw_pkg::PARAM_W-1:0] i_mismatch;
	logic [sw_pkg::PARAM_W-1:0] i_gap_open;
	logic [sw_pkg::PARAM_W-1:0] i_gap_extend;
	logic i_param_valid;
	logic o_busy;
	logic signed [sw_pkg::SCORE_W-1:0] o_result;
	logic o_valid;

	int seed = 65;
	int limit_cycles = 0;

	// model state, scoring kept as positive magnitudes
	logic [1:0] t_mem [0:sw_pkg::MAX_T-1];
	int t_len;
	int p_match;
	int p_mismatch;
	int p_open;
	int p_extend;

	sw_top UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_set_t       (i_set_t),
		.i_t_len       (i_t_len),
		.i_t_base      (i_t_base),
		.i_t_valid     (i_t_valid),
		.o_t_ready     (o_t_ready),
		.i_start_cal   (i_start_cal),
		.i_s           (i_s),
		.i_s_len       (i_s_len),
		.i_match       (i_match),
		.i_mismatch    (i_mismatch),
		.i_gap_open    (i_gap_open),
		.i_gap_extend  (i_gap_extend),
		.i_param_valid (i_param_valid),
		.o_busy        (o_busy),
		.o_result      (o_result),
		.o_valid       (o_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int pick(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	function automatic logic [sw_pkg::PE_NUM*2-1:0] random_s();
		logic [31:0] r;
		r = $random(seed);
		return r[sw_pkg::PE_NUM*2-1:0];
	endfunction

	function automatic int imax(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// full affine-gap matrix, rows follow T, columns the first m bases of S
	function automatic int model_score(input logic [sw_pkg::PE_NUM*2-1:0] s, input int m);
		int h [0:sw_pkg::MAX_T][0:sw_pkg::PE_NUM];
		int e [0:sw_pkg::MAX_T][0:sw_pkg::PE_NUM];
		int f [0:sw_pkg::MAX_T][0:sw_pkg::PE_NUM];
		int i;
		int j;
		int diag;
		int best;
		best = 0;
		for (i = 0; i <= t_len; i++) begin
			for (j = 0; j <= m; j++) begin
				h[i][j] = 0;
				e[i][j] = NEG_INF;
				f[i][j] = NEG_INF;
			end
		end
		for (i = 1; i <= t_len; i++) begin
			for (j = 1; j <= m; j++) begin
				e[i][j] = imax(h[i-1][j] - p_open, e[i-1][j] - p_extend);
				f[i][j] = imax(h[i][j-1] - p_open, f[i][j-1] - p_extend);
				diag = h[i-1][j-1] + ((t_mem[i-1] == s[2*(j-1) +: 2]) ? p_match : -p_mismatch);
				h[i][j] = imax(imax(0, diag), imax(e[i][j], f[i][j]));
				best = imax(best, h[i][j]);
			end
		end
		return best;
	endfunction

	task automatic check_score(input string name, input logic signed [sw_pkg::SCORE_W-1:0] got,
		input logic signed [sw_pkg::SCORE_W-1:0] want);
		if (got !== want) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
			$display("TEST RESULT: FAIL");
			$fatal(1, "score mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
			$display("TEST RESULT: FAIL");
			$fatal(1, "control bit mismatch");
		end
	endtask

	task automatic wait_busy(input logic level);
		@(negedge clk);
		while (o_busy !== level)
			@(negedge clk);
	endtask

	task automatic drive_params(input int mat, input int mis, input int opn, input int ext);
		@(posedge clk);
		i_match <= sw_pkg::PARAM_W'(mat);
		i_mismatch <= sw_pkg::PARAM_W'(mis);
		i_gap_open <= sw_pkg::PARAM_W'(opn);
		i_gap_extend <= sw_pkg::PARAM_W'(ext);
		i_param_valid <= 1'b1;
		@(posedge clk);
		i_param_valid <= 1'b0;
	endtask

	task automatic apply_params();
		p_match = pick(1, 10);
		p_mismatch = pick(0, 8);
		p_open = pick(0, 8);
		p_extend = pick(0, 4);
		drive_params(p_match, p_mismatch, p_open, p_extend);
		repeat (2) @(posedge clk);
	endtask

	task automatic load_t(input int len);
		int idx;
		bit xfer;
		logic [31:0] r;
		t_len = len;
		for (idx = 0; idx < len; idx++) begin
			r = $random(seed);
			t_mem[idx] = r[1:0];
		end
		@(posedge clk);
		i_set_t <= 1'b1;
		i_t_len <= sw_pkg::MAX_T_LOG'(len);
		i_t_valid <= 1'b1;
		i_t_base <= t_mem[0];
		@(posedge clk);
		i_set_t <= 1'b0;
		idx = 0;
		// transfer happens on the edge after both are seen high
		while (idx < len) begin
			@(negedge clk);
			xfer = o_t_ready && i_t_valid;
			@(posedge clk);
			if (xfer)
				idx++;
			if (idx < len) begin
				i_t_valid <= (pick(0, 3) != 0);
				i_t_base <= t_mem[idx];
			end else begin
				i_t_valid <= 1'b0;
			end
		end
		wait_busy(1'b0);
		check_bit("o_t_ready", o_t_ready, 1'b0);
	endtask

	task automatic run_calc(input logic [sw_pkg::PE_NUM*2-1:0] s, input int s_len,
		input bit change_mid);
		int want;
		int nm;
		int nmis;
		int nopen;
		int next;
		logic signed [sw_pkg::SCORE_W-1:0] want_score;
		want = model_score(s, s_len);
		want_score = sw_pkg::SCORE_W'(want);
		@(posedge clk);
		i_s <= s;
		i_s_len <= sw_pkg::PE_NUM_LOG'(s_len);
		i_start_cal <= 1'b1;
		@(posedge clk);
		i_start_cal <= 1'b0;
		wait_busy(1'b1);
		if (change_mid) begin
			// should be dropped, the run keeps the old values
			nm = pick(1, 10);
			nmis = pick(0, 8);
			nopen = pick(0, 8);
			next = pick(0, 4);
			drive_params(nm, nmis, nopen, next);
		end
		@(negedge clk);
		while (!o_valid)
			@(negedge clk);
		check_score("o_result", o_result, want_score);
		check_bit("o_busy", o_busy, 1'b1);
		@(negedge clk);
		check_bit("o_valid", o_valid, 1'b0);
		check_bit("o_busy", o_busy, 1'b0);
	endtask

	initial begin
		int la;
		int lb;
		int k;
		rst_n = 1'b0;
		i_set_t = 1'b0;
		i_t_len = '0;
		i_t_base = '0;
		i_t_valid = 1'b0;
		i_start_cal = 1'b0;
		i_s = '0;
		i_s_len = '0;
		i_match = sw_pkg::PARAM_W'(sw_pkg::DEF_MATCH);
		i_mismatch = sw_pkg::PARAM_W'(sw_pkg::DEF_MISMATCH);
		i_gap_open = sw_pkg::PARAM_W'(sw_pkg::DEF_OPEN);
		i_gap_extend = sw_pkg::PARAM_W'(sw_pkg::DEF_EXTEND);
		i_param_valid = 1'b0;
		p_match = sw_pkg::DEF_MATCH;
		p_mismatch = sw_pkg::DEF_MISMATCH;
		p_open = sw_pkg::DEF_OPEN;
		p_extend = sw_pkg::DEF_EXTEND;
		t_len = 0;

		la = pick(1, sw_pkg::MAX_T);
		lb = pick(1, sw_pkg::MAX_T);
		limit_cycles = 8 + N_TESTS * 200
			+ (N_DEF + N_PARAM + N_MID + N_SLEN) * (la + sw_pkg::PE_NUM)
			+ N_NEW * (lb + sw_pkg::PE_NUM);

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// idle after reset, start without T is ignored
		@(negedge clk);
		check_bit("o_busy", o_busy, 1'b0);
		check_bit("o_t_ready", o_t_ready, 1'b0);
		@(posedge clk);
		i_start_cal <= 1'b1;
		@(posedge clk);
		i_start_cal <= 1'b0;
		repeat (20) begin
			@(negedge clk);
			check_bit("o_busy", o_busy, 1'b0);
		end

		load_t(la);
		for (k = 0; k < N_DEF; k++)
			run_calc(random_s(), sw_pkg::PE_NUM, 1'b0);
		for (k = 0; k < N_PARAM; k++) begin
			apply_params();
			run_calc(random_s(), sw_pkg::PE_NUM, 1'b0);
		end
		for (k = 0; k < N_MID; k++)
			run_calc(random_s(), sw_pkg::PE_NUM, 1'b1);
		for (k = 0; k < N_SLEN; k++)
			run_calc(random_s(), pick(1, sw_pkg::PE_NUM), 1'b0);

		// new query replaces the old one
		load_t(lb);
		for (k = 0; k < N_NEW; k++)
			run_calc(random_s(), sw_pkg::PE_NUM, 1'b0);

		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("run timed out after %0d cycles", limit_cycles);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* list.f */
design/sw_pkg.sv
design/sw_pe.sv
design/t_store.sv
design/pe_array.sv
design/sw_top.sv
test/sw_checker.sv
test/sw_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the Smith-Waterman testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f list.f \
	--top-module sw_tb \
	-o sw_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sw_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0
